// ==== Makefile ====
TOP = tb_photon_uart

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

# Exit status comes from the search for the pass line.
sim:
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null

clean:
	rm -rf obj_dir

// ==== bench/photon_golden.txt ====
// sel  pulse_period  expected_count  expected_code  frames_to_check
// Decimal. Pulse period divides the window, so count = window / period.
6   10   40   1   4
7   25   80   2   4
12  8    50   1   3
6   16   25   1   3
7   20   100  2   2

// ==== bench/tb_photon_uart.sv ====
`timescale 1ns/1ps

module tb_photon_uart;
    import photon_pkg::*;

    localparam int SETTLE_FRAMES = 2; // Frames skipped after each resume.
    localparam int MAX_PHASES    = 8;

    logic       clk = 1'b0;
    logic       photon_pulse = 1'b0;
    logic       rst_n, en, tx, frame_done, quiet;
    logic [7:0] interval_sel;
    logic [7:0] frame_buf [14];   // Bytes of the frame being received.
    int sel_g [MAX_PHASES];
    int period_g [MAX_PHASES];
    int count_g [MAX_PHASES];
    int code_g [MAX_PHASES];
    int frames_g [MAX_PHASES];
    int n_phases = 0;
    int cur_phase = 0;
    int phase_start = 0;          // Frames decoded before this phase.
    int frames_decoded = 0;
    int done_count = 0;
    int byte_idx = 0;
    int value_errors = 0;
    int other_errors = 0;
    int pulse_period = 10;
    int pulse_cnt = 0;
    int seed;

    photon_uart_top dut (
        .clk(clk), .rst_n(rst_n), .en(en), .photon_pulse(photon_pulse),
        .interval_sel(interval_sel), .tx(tx), .frame_done(frame_done)
    );

    always #50 clk = ~clk; // 100 ns period.

    // Periodic pulse train, two clocks high.
    always @(posedge clk) begin
        if (pulse_cnt >= pulse_period - 1)
            pulse_cnt <= 0;
        else
            pulse_cnt <= pulse_cnt + 1;
        photon_pulse <= (pulse_cnt < 2);
    end

    task automatic check_value(input string name, input int exp, input int got);
        assert (got == exp) else begin
            value_errors++;
            $display("CHECK FAILED at %0t ns: %s expected 0x%0h got 0x%0h",
                     $time, name, exp, got);
        end
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // Comment lines fail the five-field scan and are skipped.
    task automatic load_golden();
        int fd;
        string line;
        int s, pr, c, cd, f;
        fd = $fopen("bench/photon_golden.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open bench/photon_golden.txt");
            return;
        end
        while (!$feof(fd) && n_phases < MAX_PHASES) begin
            void'($fgets(line, fd));
            if ($sscanf(line, "%d %d %d %d %d", s, pr, c, cd, f) == 5) begin
                sel_g[n_phases]    = s;
                period_g[n_phases] = pr;
                count_g[n_phases]  = c;
                code_g[n_phases]   = cd;
                frames_g[n_phases] = f;
                n_phases++;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////
    // Frame checks.
    ////////////////////////////////////////
    task automatic check_frame();
        int k, i, sum, prev_sub;
        k = frames_decoded;
        sum = 0;
        prev_sub = ((k - 1) % 10) + 1;
        for (i = 0; i < 13; i++)
            sum += int'(frame_buf[i]);
        check_value("sync head 0", int'(SYNC_HEAD0), int'(frame_buf[0]));
        check_value("sync head 1", int'(SYNC_HEAD1), int'(frame_buf[1]));
        check_value("length", int'(PAYLOAD_LEN), int'({frame_buf[2], frame_buf[3]}));
        check_value("phase", (k == 0) ? int'(PHASE_STEP) : int'(PHASE_STEP) * prev_sub,
                    int'({frame_buf[4], frame_buf[5]}));
        check_value("total gaps", int'(GAPS_PER_CYCLE), int'({frame_buf[8], frame_buf[9]}));
        check_value("sub-gap", (k % 10) + 1, int'({frame_buf[10], frame_buf[11]}));
        check_value("interval code", code_g[cur_phase], int'(frame_buf[12]));
        check_value("checksum", sum & 255, int'(frame_buf[13]));
        if (k - phase_start >= SETTLE_FRAMES) begin // Window settled.
            check_value("count", count_g[cur_phase], int'({frame_buf[6], frame_buf[7]}));
        end
        frames_decoded++;
    endtask

    // Serial decoder, samples mid-bit on falling edges.
    initial begin : serial_rx
        logic [7:0] data;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    data[i] = tx; // LSB first.
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                assert (tx === 1'b1) else report_problem("missing stop bit on tx");
                frame_buf[byte_idx] = data;
                byte_idx++;
                if (byte_idx == 14) begin
                    check_frame();
                    byte_idx = 0;
                end
            end
        end
    end

    // One frame_done per finished frame; line quiet while paused.
    always @(negedge clk) begin
        if (frame_done === 1'b1) begin
            assert (done_count < frames_decoded)
                else report_problem("frame_done pulse without a finished frame");
            done_count++;
        end
        if (quiet) begin
            assert (tx === 1'b1) else begin
                report_problem("tx active while en is low");
                quiet = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Phase sequence.
    ////////////////////////////////////////
    initial begin : main
        int idle, limit, frame_clks, work, max_window;
        rst_n = 1'b0;
        en = 1'b0;
        interval_sel = 8'd6;
        quiet = 1'b0;
        seed = 72942;
        load_golden();
        frame_clks = 14 * (10 * int'(CLKS_PER_BIT) + 4) + 3;
        work = 0;
        max_window = 0;
        for (int p = 0; p < n_phases; p++) begin
            work += (SETTLE_FRAMES + frames_g[p]) * frame_clks;
            if (count_g[p] * period_g[p] > max_window)
                max_window = count_g[p] * period_g[p];
        end
        limit = 2 * (work + max_window) + n_phases * 600 + 1000;
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("Timeout: run exceeded %0d clocks", limit);
                $display("*** FAILED ***");
                $finish;
            end
        join_none
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int p = 0; p < n_phases; p++) begin
            @(posedge clk);
            interval_sel <= 8'(sel_g[p]);
            pulse_period <= period_g[p];
            idle = 200 + int'($unsigned($random(seed)) % 200);
            repeat (idle) @(posedge clk);
            quiet = 1'b0;
            cur_phase = p;
            phase_start = frames_decoded;
            en <= 1'b1;
            while (frames_decoded - phase_start < SETTLE_FRAMES + frames_g[p])
                @(posedge clk);
            while (done_count < frames_decoded)
                @(posedge clk); // Done pulse of the last frame.
            repeat (10) @(posedge clk); // Drop en inside the next head byte.
            en <= 1'b0;
            repeat (10 * int'(CLKS_PER_BIT) + 4) @(posedge clk);
            quiet = 1'b1;
        end
        repeat (200) @(posedge clk);
        assert (n_phases > 0) else report_problem("no test phases were read");
        assert (done_count == frames_decoded)
            else report_problem("frame_done count differs from decoded frames");
        $display("Summary: %0d frames, %0d value errors, %0d other errors",
                 frames_decoded, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== build.f ====
hw/photon_pkg.sv
hw/uart_tx.sv
hw/gap_timer.sv
hw/photon_counter.sv
hw/frame_dump.sv
hw/photon_uart_top.sv
bench/tb_photon_uart.sv

// ==== hw/frame_dump.sv ====
`timescale 1ns/1ps

module frame_dump (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic [15:0] count,
    input  logic        count_update,
    input  logic [7:0]  interval_sel,
    input  logic        byte_done,
    output logic [7:0]  tx_byte,
    output logic        send,
    output logic        frame_done
);
    import photon_pkg::*;

    logic [4:0]  step;         // Frame step, 0..16.
    logic [15:0] held_count;   // Newest count from the counter.
    logic [15:0] locked_count; // Count carried by this frame.
    logic [15:0] phase;        // Mains phase in degrees.
    logic [7:0]  gap_no;       // Sub-gap, 1..10.
    logic [7:0]  code;         // Interval code sent in this frame.
    logic [7:0]  checksum;
    logic [7:0]  byte_val;     // Byte for the current step.
    logic        byte_step;

    // Steps 0..12 and 14 each put one byte on the line.
    assign byte_step = (step <= 5'd12) || (step == 5'd14);

    ////////////////////////////////////////
    // Byte for each step.
    ////////////////////////////////////////
    always_comb begin
        case (step)
            5'd0:    byte_val = SYNC_HEAD0;
            5'd1:    byte_val = SYNC_HEAD1;
            5'd2:    byte_val = 8'd0;               // Length high.
            5'd3:    byte_val = PAYLOAD_LEN;
            5'd4:    byte_val = phase[15:8];
            5'd5:    byte_val = phase[7:0];
            5'd6:    byte_val = locked_count[15:8];
            5'd7:    byte_val = locked_count[7:0];
            5'd8:    byte_val = 8'd0;               // Total gaps high.
            5'd9:    byte_val = GAPS_PER_CYCLE;
            5'd10:   byte_val = 8'd0;               // Sub-gap high.
            5'd11:   byte_val = gap_no;
            5'd12:   byte_val = interval_code(interval_sel);
            5'd14:   byte_val = checksum;
            default: byte_val = 8'd0;
        endcase
    end

    // Newest count, kept apart from the one being sent.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            held_count <= 16'd0;
        else if (count_update)
            held_count <= count;
    end

    ////////////////////////////////////////
    // Frame sequencer.
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step         <= 5'd0;
            send         <= 1'b0;
            frame_done   <= 1'b0;
            phase        <= PHASE_STEP; // First frame carries 36.
            gap_no       <= 8'd1;
            code         <= 8'd1;
            locked_count <= 16'd0;
        end else begin
            frame_done <= 1'b0;
            if (byte_done) begin
                // Byte out, even while frozen.
                send <= 1'b0;
                step <= step + 5'd1;
            end else if (!en) begin
                send <= 1'b0; // Hold step, start nothing new.
            end else if (byte_step) begin
                send <= 1'b1;
                if (step == 5'd0)
                    locked_count <= held_count;
                if (step == 5'd12)
                    code <= interval_code(interval_sel);
            end else begin
                case (step)
                    5'd13: begin
                        step <= step + 5'd1; // Zero bytes left out of the sum.
                    end
                    5'd15: begin
                        if (gap_no >= GAPS_PER_CYCLE)
                            gap_no <= 8'd1; // Wrap after ten.
                        else
                            gap_no <= gap_no + 8'd1;
                        phase      <= PHASE_STEP * {8'd0, gap_no}; // Sent in the next frame.
                        frame_done <= 1'b1;
                        step       <= step + 5'd1;
                    end
                    default: step <= 5'd0; // Idle step, then next frame.
                endcase
            end
        end
    end

    // Payload bytes and checksum.
    always_ff @(posedge clk) begin
        if (en && byte_step && !byte_done)
            tx_byte <= byte_val;
        if (en && step == 5'd13 && !byte_done)
            checksum <= SYNC_HEAD0 + SYNC_HEAD1 + PAYLOAD_LEN
                      + phase[15:8] + phase[7:0]
                      + locked_count[15:8] + locked_count[7:0]
                      + GAPS_PER_CYCLE + gap_no + code;
    end

    // No byte requested in the checksum and done steps.
    a_quiet_steps: assert property (@(posedge clk) disable iff (!rst_n)
        (step == 5'd13 || step == 5'd15) |-> !send)
        else $error("frame_dump: send high in a non-byte step");

    a_gap_range: assert property (@(posedge clk) disable iff (!rst_n)
        gap_no >= 8'd1 && gap_no <= GAPS_PER_CYCLE)
        else $error("frame_dump: gap_no out of range");

endmodule

// ==== hw/gap_timer.sv ====
`timescale 1ns/1ps

module gap_timer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic [7:0] interval_sel,
    output logic       gap_tick
);
    import photon_pkg::*;

    logic [15:0] unit_cnt; // Clocks within one base unit.
    logic [7:0]  unit_no;  // Units within the current gap.
    logic [7:0]  target;   // Units per gap, taken at each tick.
    logic        unit_last;

    assign unit_last = (unit_cnt == BASE_CLKS - 1);

    // Last clock of the last unit.
    assign gap_tick = en && unit_last && (unit_no == target - 8'd1);

    ////////////////////////////////////////
    // Unit and gap counters.
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unit_cnt <= 16'd0;
            unit_no  <= 8'd0;
            target   <= 8'd1; // First gap is one unit long.
        end else if (en) begin // Frozen while en is low.
            if (unit_last) begin
                unit_cnt <= 16'd0;
                if (gap_tick) begin
                    unit_no <= 8'd0;
                    // New selection applies from this tick on.
                    target  <= interval_units(interval_code(interval_sel));
                end else begin
                    unit_no <= unit_no + 8'd1;
                end
            end else begin
                unit_cnt <= unit_cnt + 16'd1;
            end
        end
    end

    // Unit counter stays below the gap length.
    a_unit_range: assert property (@(posedge clk) disable iff (!rst_n)
        unit_no < target)
        else $error("gap_timer: unit count past target");

endmodule

// ==== hw/photon_counter.sv ====
`timescale 1ns/1ps

module photon_counter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        photon_pulse,
    input  logic        gap_tick,
    output logic [15:0] count,
    output logic        count_update
);
    import photon_pkg::*;

    logic [2:0]  sync;    // Two sync flops plus edge history.
    logic        rise;
    logic [15:0] run_cnt; // Count in the open window.

    assign rise = sync[1] && !sync[2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync         <= 3'b000;
            run_cnt      <= 16'd0;
            count        <= 16'd0;
            count_update <= 1'b0;
        end else begin
            sync         <= {sync[1:0], photon_pulse};
            count_update <= gap_tick; // Valid with the latched count.
            if (gap_tick) begin
                count   <= run_cnt;
                run_cnt <= rise ? 16'd1 : 16'd0; // Edge on the tick opens the new window.
            end else if (rise && run_cnt != 16'hFFFF) begin
                run_cnt <= run_cnt + 16'd1; // Saturates at full scale.
            end
        end
    end

    // Gap windows are longer than one clock.
    a_update_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        count_update |=> !count_update)
        else $error("photon_counter: count_update longer than one cycle");

endmodule

// ==== hw/photon_pkg.sv ====
package photon_pkg;

    ////////////////////////////////////////
    // Link timing, scaled for simulation.
    ////////////////////////////////////////
    localparam logic [15:0] CLKS_PER_BIT = 16'd16;  // Clocks per serial bit.
    localparam logic [15:0] BASE_CLKS    = 16'd400; // One 2 ms gap unit.

    ////////////////////////////////////////
    // Frame layout.
    ////////////////////////////////////////
    localparam logic [7:0] SYNC_HEAD0     = 8'h55;
    localparam logic [7:0] SYNC_HEAD1     = 8'hAA;
    localparam logic [7:0] PAYLOAD_LEN    = 8'd10;  // Phase..checksum, in bytes.
    localparam logic [7:0] GAPS_PER_CYCLE = 8'd10;  // 20 ms mains cycle / 2 ms.
    localparam logic [15:0] PHASE_STEP    = 16'd36; // 360 degrees / 10 gaps.

    // Selection byte to interval code.
    function automatic logic [7:0] interval_code(input logic [7:0] sel);
        case (sel)
            8'd6:    return 8'd1; // 2 ms.
            8'd7:    return 8'd2; // 10 ms.
            8'd8:    return 8'd3; // 100 ms.
            8'd9:    return 8'd4; // 500 ms.
            default: return 8'd1; // Unknown falls back to 2 ms.
        endcase
    endfunction

    // Interval code to number of base units per gap.
    function automatic logic [7:0] interval_units(input logic [7:0] code);
        case (code)
            8'd2:    return 8'd5;
            8'd3:    return 8'd50;
            8'd4:    return 8'd250;
            default: return 8'd1;
        endcase
    endfunction

endpackage

// ==== hw/photon_uart_top.sv ====
`timescale 1ns/1ps

module photon_uart_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       photon_pulse,
    input  logic [7:0] interval_sel,
    output logic       tx,
    output logic       frame_done
);

    logic        gap_tick;
    logic [15:0] count;
    logic        count_update;
    logic [7:0]  tx_byte;
    logic        send;
    logic        byte_done;

    ////////////////////////////////////////
    // Window timing and counting.
    ////////////////////////////////////////
    gap_timer u_gap_timer (
        .clk(clk), .rst_n(rst_n), .en(en),
        .interval_sel(interval_sel), .gap_tick(gap_tick)
    );

    photon_counter u_photon_counter (
        .clk(clk), .rst_n(rst_n), .photon_pulse(photon_pulse),
        .gap_tick(gap_tick), .count(count), .count_update(count_update)
    );

    ////////////////////////////////////////
    // Framing and serial line.
    ////////////////////////////////////////
    frame_dump u_frame_dump (
        .clk(clk), .rst_n(rst_n), .en(en), .count(count),
        .count_update(count_update), .interval_sel(interval_sel),
        .byte_done(byte_done), .tx_byte(tx_byte), .send(send),
        .frame_done(frame_done)
    );

    uart_tx u_uart_tx (
        .clk(clk), .rst_n(rst_n), .tx_byte(tx_byte), .send(send),
        .byte_done(byte_done), .tx(tx)
    );

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_byte,
    input  logic       send,
    output logic       byte_done,
    output logic       tx
);
    import photon_pkg::*;

    logic        busy;     // Byte in flight.
    logic        armed;    // Send seen low since last start.
    logic [3:0]  bit_idx;  // 0 start, 1..8 data, 9 stop.
    logic [15:0] clk_cnt;  // Clocks within current bit.
    logic [7:0]  shreg;    // Data bits still to go out.
    logic        bit_end;
    logic        start;

    assign bit_end   = (clk_cnt == CLKS_PER_BIT - 1);
    assign start     = !busy && send && armed;
    assign byte_done = busy && bit_end && (bit_idx == 4'd9); // Last clock of stop.

    ////////////////////////////////////////
    // Bit sequencer.
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            armed   <= 1'b1;
            bit_idx <= 4'd0;
            clk_cnt <= 16'd0;
            tx      <= 1'b1; // Line idles high.
        end else begin
            if (!send)
                armed <= 1'b1; // Rearm once send has dropped.
            if (start) begin
                busy    <= 1'b1;
                armed   <= 1'b0;
                bit_idx <= 4'd0;
                clk_cnt <= 16'd0;
                tx      <= 1'b0; // Start bit.
            end else if (busy) begin
                if (bit_end) begin
                    clk_cnt <= 16'd0;
                    if (bit_idx == 4'd9) begin
                        busy <= 1'b0; // Stop bit done, tx stays high.
                    end else begin
                        bit_idx <= bit_idx + 4'd1;
                        tx      <= (bit_idx == 4'd8) ? 1'b1 : shreg[0];
                    end
                end else begin
                    clk_cnt <= clk_cnt + 16'd1;
                end
            end
        end
    end

    // Shift register, LSB first.
    always_ff @(posedge clk) begin
        if (start)
            shreg <= tx_byte;
        else if (busy && bit_end && bit_idx <= 4'd7)
            shreg <= {1'b0, shreg[7:1]};
    end

    // Line is high while idle and in the last clock of the stop bit.
    a_line_high: assert property (@(posedge clk) disable iff (!rst_n)
        (!busy || byte_done) |-> tx)
        else $error("uart_tx: tx low while idle or at byte_done");

endmodule
